// File: logic/if_stage_pkg.sv
// Shared definitions of the instruction fetch stage
// Widths, PC source codes, opcodes and the two views of an instruction word
package if_stage_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int XLEN             = 32;  // Address and instruction width
  localparam int MTVEC_ADDR_WIDTH = 25;  // mtvec base, 128 byte aligned
  localparam int IRQ_ID_WIDTH     = 5;   // Interrupt index for vectoring

  //////////////////////////////////////////////////
  // PC source select
  //////////////////////////////////////////////////

  // Code driven by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT     = 3'b000,  // Boot address
    PC_JUMP     = 3'b001,  // Jump target from ID
    PC_BRANCH   = 3'b010,  // Taken branch from EX
    PC_MRET     = 3'b011,  // Return to mepc
    PC_TRAP_EXC = 3'b100,  // Exception, mtvec base
    PC_TRAP_IRQ = 3'b101   // Interrupt, vectored off mtvec
  } pc_mux_e;

  //////////////////////////////////////////////////
  // Opcodes and instruction word layout
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU

  // R/I-type field split of a full word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_fields_t;

  // CI/CR split of the low parcel
  typedef struct packed {
    logic [15:0] unused;    // Following parcel, not part of the RVC word
    logic [2:0]  funct3;
    logic        imm5;      // imm[5], or funct4 bit 0 in quadrant 2
    logic [4:0]  rd_rs1;    // Destination and first source
    logic [4:0]  rs2_imm;   // rs2 or imm[4:0]
    logic [1:0]  quadrant;  // 2'b11 marks a full 32-bit word
  } rvc_fields_t;

  // Fetched word, read as a full instruction or as its compressed half
  typedef union packed {
    rv32_fields_t rv32;
    rvc_fields_t  rvc;
  } instr_word_u;

endpackage

// File: logic/pc_select.sv
// Next fetch address mux driven by the controller PC code
// Also flags mtvec initialization on boot
module pc_select import if_stage_pkg::*; (
  input  logic                        pc_set_i,          // One-cycle redirect strobe
  input  pc_mux_e                     pc_mux_i,          // Source select
  input  logic [XLEN-1:0]             boot_addr_i,
  input  logic [XLEN-1:0]             jump_target_i,
  input  logic [XLEN-1:0]             branch_target_i,
  input  logic [XLEN-1:0]             mepc_i,            // Return address of a trap
  input  logic [MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i,      // Trap vector base, upper bits
  input  logic [IRQ_ID_WIDTH-1:0]     irq_id_i,          // Interrupt being taken
  output logic [XLEN-1:0]             branch_addr_o,     // Halfword aligned target
  output logic                        csr_mtvec_init_o   // Load mtvec from boot address
);

  logic [XLEN-1:0] addr_n;  // Selected target, before bit 0 is dropped

  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     addr_n = {boot_addr_i[XLEN-1:2], 2'b00};  // Word aligned boot
      PC_JUMP:     addr_n = jump_target_i;
      PC_BRANCH:   addr_n = branch_target_i;
      PC_MRET:     addr_n = mepc_i;
      // Every exception enters at the vector base
      PC_TRAP_EXC: addr_n = {mtvec_addr_i, {(XLEN - MTVEC_ADDR_WIDTH){1'b0}}};
      // One word per interrupt line
      PC_TRAP_IRQ: addr_n = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     addr_n = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // Fetch is never byte aligned
  assign branch_addr_o = {addr_n[XLEN-1:1], 1'b0};

  // CSR file latches mtvec only when the core boots
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // The controller only redirects through the supported sources
  always_comb begin
    if (pc_set_i) begin
      assert (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_BRANCH, PC_MRET, PC_TRAP_EXC, PC_TRAP_IRQ})
        else $error("pc_select: undefined PC mux code %0d", pc_mux_i);
    end
  end

endmodule

// File: logic/fetch_unit.sv
// Fetch PC, single outstanding request tracking and one-entry instruction buffer
// Stale responses after a redirect are dropped
module fetch_unit import if_stage_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pc_set_i,       // Redirect
  input  logic [XLEN-1:0] branch_addr_i,  // Redirect target
  input  logic            fetch_valid_i,  // Memory response strobe
  input  logic [XLEN-1:0] fetch_rdata_i,
  input  logic            pop_i,          // Stage consumed the buffer
  input  logic            flush_i,        // Kill, drop the buffer
  output logic            fetch_req_o,    // Single-cycle request pulse
  output logic [XLEN-1:0] fetch_addr_o,
  output logic            buf_valid_o,
  output logic [XLEN-1:0] buf_word_o,
  output logic [XLEN-1:0] buf_pc_o
);

  // Fetch states
  localparam logic [1:0] S_IDLE = 2'd0;  // Nothing outstanding, buffer empty
  localparam logic [1:0] S_WAIT = 2'd1;  // Request on the bus
  localparam logic [1:0] S_HOLD = 2'd2;  // Buffer full

  logic [1:0]      state_q;
  logic            req_q;      // Issue a request this cycle
  logic            discard_q;  // Outstanding response belongs to an old PC
  logic [XLEN-1:0] pc_q;       // PC of the buffered or requested word
  logic [XLEN-1:0] word_q;     // Buffered instruction word
  logic            in_flight;  // A request is still open after this edge
  logic            resp_keep;  // Response goes into the buffer
  logic            advance;    // Buffer leaves, move to next PC
  logic [XLEN-1:0] pc_step;
  logic            req_open_q; // Bus view of an unanswered request

  assign in_flight = req_q || (state_q == S_WAIT && !fetch_valid_i);
  assign resp_keep = (state_q == S_WAIT) && fetch_valid_i && !discard_q && !pc_set_i;
  assign advance   = (state_q == S_HOLD) && (pop_i || flush_i);
  assign pc_step   = (word_q[1:0] != 2'b11) ? XLEN'(2) : XLEN'(4);  // RVC or full word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      req_q     <= 1'b0;
      discard_q <= 1'b0;
      pc_q      <= '0;
    end else if (pc_set_i) begin
      // New target, request now or once the open one returns
      pc_q      <= branch_addr_i;
      req_q     <= !in_flight;
      discard_q <= in_flight;
      state_q   <= in_flight ? S_WAIT : S_IDLE;
    end else if (req_q) begin
      req_q   <= 1'b0;  // Pulse goes out this cycle
      state_q <= S_WAIT;
    end else begin
      case (state_q)
        S_WAIT: begin
          if (fetch_valid_i) begin
            req_q     <= discard_q;                    // Refetch after a stale reply
            discard_q <= 1'b0;
            state_q   <= discard_q ? S_IDLE : S_HOLD;
          end
        end
        S_HOLD: begin
          if (advance) begin
            pc_q    <= pc_q + pc_step;
            req_q   <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: ;
      endcase
    end
  end

  // Buffered word
  always_ff @(posedge clk) begin
    if (resp_keep) begin
      word_q <= fetch_rdata_i;
    end
  end

  assign fetch_req_o  = req_q;
  assign fetch_addr_o = pc_q;
  assign buf_valid_o  = (state_q == S_HOLD);
  assign buf_word_o   = word_q;
  assign buf_pc_o     = pc_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Request pulses and response strobes as seen on the bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_open_q <= 1'b0;
    end else if (fetch_req_o) begin
      req_open_q <= 1'b1;
    end else if (fetch_valid_i) begin
      req_open_q <= 1'b0;
    end
  end

  // Memory answers only what was asked
  a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_i |-> state_q == S_WAIT)
    else $error("fetch_unit: response without a pending request");

  // One outstanding request at a time
  a_no_req_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req_o |-> !req_open_q)
    else $error("fetch_unit: request while another is outstanding");

endmodule

// File: logic/rvc_expander.sv
// Compressed instruction expander for C.ADDI, C.NOP, C.LI, C.MV and C.ADD
// Unsupported compressed forms are flagged illegal and pass through raw
module rvc_expander import if_stage_pkg::*; (
  input  instr_word_u     instr_i,       // Buffered fetch word
  output logic [XLEN-1:0] instr_o,       // Expanded or raw word
  output logic            compressed_o,  // Low parcel is an RVC instruction
  output logic            illegal_o      // RVC form not supported
);

  logic [XLEN-1:0] raw;       // Word as fetched
  logic [11:0]     imm_sext;  // CI immediate, sign extended
  rv32_fields_t    exp;       // Expanded instruction

  assign raw      = instr_i;
  assign imm_sext = {{7{instr_i.rvc.imm5}}, instr_i.rvc.rs2_imm};

  // Full words end in 2'b11
  assign compressed_o = (instr_i.rv32.opcode[1:0] != 2'b11);

  always_comb begin
    exp       = '0;
    instr_o   = raw;
    illegal_o = 1'b0;

    if (compressed_o) begin
      illegal_o = 1'b1;  // Cleared by a supported form
      case (instr_i.rvc.quadrant)
        2'b01: begin
          if (instr_i.rvc.funct3 == 3'b000 || instr_i.rvc.funct3 == 3'b010) begin
            // C.ADDI / C.NOP is addi rd, rd, imm
            // C.LI is addi rd, x0, imm
            {exp.funct7, exp.rs2} = imm_sext;
            exp.rs1       = (instr_i.rvc.funct3 == 3'b000) ? instr_i.rvc.rd_rs1 : 5'd0;
            exp.funct3    = 3'b000;
            exp.rd        = instr_i.rvc.rd_rs1;
            exp.opcode    = OPC_OP_IMM;
            instr_o       = exp;
            illegal_o     = 1'b0;
          end
        end
        2'b10: begin
          // rs2 of zero selects C.JR, C.JALR, C.EBREAK
          if (instr_i.rvc.funct3 == 3'b100 && instr_i.rvc.rs2_imm != 5'd0) begin
            exp.funct7 = 7'b0000000;
            exp.rs2    = instr_i.rvc.rs2_imm;
            exp.rs1    = instr_i.rvc.imm5 ? instr_i.rvc.rd_rs1 : 5'd0;  // C.ADD or C.MV
            exp.funct3 = 3'b000;
            exp.rd     = instr_i.rvc.rd_rs1;
            exp.opcode = OPC_OP;
            instr_o    = exp;
            illegal_o  = 1'b0;
          end
        end
        default: ;  // Quadrant 0 incl. all-zero word
      endcase
    end
  end

endmodule

// File: logic/if_id_register.sv
// IF/ID pipeline register
// Holds while ID stalls, clears valid when ID takes nothing new
module if_id_register import if_stage_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            load_i,           // IF valid and ID ready
  input  logic            id_ready_i,
  input  logic [XLEN-1:0] instr_i,          // Expanded instruction
  input  logic [XLEN-1:0] pc_i,
  input  logic            compressed_i,
  input  logic            illegal_i,
  input  logic [15:0]     raw_half_i,       // Original compressed parcel
  output logic            id_valid_o,
  output logic [XLEN-1:0] id_instr_o,
  output logic [XLEN-1:0] id_pc_o,
  output logic            id_compressed_o,
  output logic            id_illegal_o,
  output logic [15:0]     id_raw_half_o
);

  // Valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (load_i) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;  // Consumed with nothing behind it
    end
  end

  // Payload, frozen unless a new entry loads
  always_ff @(posedge clk) begin
    if (load_i) begin
      id_instr_o      <= instr_i;
      id_pc_o         <= pc_i;
      id_compressed_o <= compressed_i;
      id_illegal_o    <= illegal_i;
      id_raw_half_o   <= raw_half_i;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // A stalled entry stays put until ID takes it
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (id_valid_o && !id_ready_i) |=> id_valid_o && $stable(id_instr_o) && $stable(id_pc_o)
      && $stable(id_compressed_o) && $stable(id_illegal_o) && $stable(id_raw_half_o))
    else $error("if_id_register: outputs changed during a stall");

endmodule

// File: logic/if_stage.sv
// Instruction fetch stage top level
// Address mux, fetch unit, RVC expander and IF/ID register with stage handshake
module if_stage import if_stage_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // Redirect from the controller
  input  logic                        pc_set_i,
  input  pc_mux_e                     pc_mux_i,
  input  logic [XLEN-1:0]             boot_addr_i,
  input  logic [XLEN-1:0]             jump_target_i,
  input  logic [XLEN-1:0]             branch_target_i,
  input  logic [XLEN-1:0]             mepc_i,
  input  logic [MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i,
  input  logic [IRQ_ID_WIDTH-1:0]     irq_id_i,
  input  logic                        halt_if_i,        // Freeze IF
  input  logic                        kill_if_i,        // Drop what IF holds
  output logic                        csr_mtvec_init_o,
  // Fetch bus
  output logic                        fetch_req_o,
  output logic [XLEN-1:0]             fetch_addr_o,
  input  logic                        fetch_valid_i,
  input  logic [XLEN-1:0]             fetch_rdata_i,
  // IF/ID outputs
  input  logic                        id_ready_i,
  output logic                        id_valid_o,
  output logic [XLEN-1:0]             id_instr_o,
  output logic [XLEN-1:0]             id_pc_o,
  output logic                        id_compressed_o,
  output logic                        id_illegal_o,
  output logic [15:0]                 id_raw_half_o
);

  logic [XLEN-1:0] branch_addr;       // Aligned redirect target
  logic            buf_valid;
  logic [XLEN-1:0] buf_word;
  logic [XLEN-1:0] buf_pc;
  logic [XLEN-1:0] instr_exp;         // Expanded instruction
  logic            instr_compressed;
  logic            instr_illegal;
  logic            if_valid;
  logic            if_ready;

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  assign if_valid = buf_valid && !kill_if_i && !halt_if_i;    // Offer only when live
  assign if_ready = kill_if_i || (id_ready_i && !halt_if_i);  // Kill always drains

  pc_select i_pc_select (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_unit i_fetch_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .fetch_valid_i (fetch_valid_i),
    .fetch_rdata_i (fetch_rdata_i),
    .pop_i         (if_ready),
    .flush_i       (kill_if_i),
    .fetch_req_o   (fetch_req_o),
    .fetch_addr_o  (fetch_addr_o),
    .buf_valid_o   (buf_valid),
    .buf_word_o    (buf_word),
    .buf_pc_o      (buf_pc)
  );

  rvc_expander i_rvc_expander (
    .instr_i      (buf_word),
    .instr_o      (instr_exp),
    .compressed_o (instr_compressed),
    .illegal_o    (instr_illegal)
  );

  if_id_register i_if_id_register (
    .clk             (clk),
    .rst_n           (rst_n),
    .load_i          (if_valid && id_ready_i),
    .id_ready_i      (id_ready_i),
    .instr_i         (instr_exp),
    .pc_i            (buf_pc),
    .compressed_i    (instr_compressed),
    .illegal_i       (instr_illegal),
    .raw_half_i      (buf_word[15:0]),
    .id_valid_o      (id_valid_o),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o),
    .id_illegal_o    (id_illegal_o),
    .id_raw_half_o   (id_raw_half_o)
  );

endmodule

// File: tests/tb_if_stage.sv
// Testbench for the instruction fetch stage
// Memory model with random latency, command player and IF/ID checker
module tb_if_stage import if_stage_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS  = 64;     // Image covers 0x000 to 0x0FF
  localparam int CMD_BASE   = 'h40;   // Four words per command
  localparam int EXP_BASE   = 'h80;   // Three words per IF/ID entry
  localparam int WAIT_LIMIT = 200;    // Cycles per wait

  logic                        clk;
  logic                        rst_n;
  logic                        pc_set_i;
  pc_mux_e                     pc_mux_i;
  logic [XLEN-1:0]             boot_addr_i;
  logic [XLEN-1:0]             jump_target_i;
  logic [XLEN-1:0]             branch_target_i;
  logic [XLEN-1:0]             mepc_i;
  logic [MTVEC_ADDR_WIDTH-1:0] mtvec_addr_i;
  logic [IRQ_ID_WIDTH-1:0]     irq_id_i;
  logic                        halt_if_i;
  logic                        kill_if_i;
  logic                        csr_mtvec_init_o;
  logic                        fetch_req_o;
  logic [XLEN-1:0]             fetch_addr_o;
  logic                        fetch_valid_i;
  logic [XLEN-1:0]             fetch_rdata_i;
  logic                        id_ready_i;
  logic                        id_valid_o;
  logic [XLEN-1:0]             id_instr_o;
  logic [XLEN-1:0]             id_pc_o;
  logic                        id_compressed_o;
  logic                        id_illegal_o;
  logic [15:0]                 id_raw_half_o;

  logic [31:0] tdata [0:255];  // Memory image, commands, expected entries
  integer      seed;
  int          n_errors;
  int          n_checks;
  int          n_accepted;     // Entries taken by ID
  int          n_exp;
  int          n_mtvec_init;
  bit          timed_out;
  bit          redirect_pend;  // Next entry must come from redirect_pc
  logic [31:0] redirect_pc;
  bit          boot_pend;      // Next request must hit boot_pc
  logic [31:0] boot_pc;
  bit          mem_busy;
  int          mem_lat;
  logic [31:0] mem_addr;
  bit          stall_q;        // Previous negedge saw a stalled entry
  logic [31:0] held_pc;
  logic [31:0] held_instr;

  if_stage i_dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // 32 bits from a halfword aligned address, little endian
  function automatic logic [31:0] read_parcels(input logic [31:0] addr);
    logic [5:0] idx;
    logic [5:0] nxt;
    idx = addr[7:2];
    nxt = idx + 6'd1;
    if (!addr[1]) return tdata[idx];
    return {tdata[nxt][15:0], tdata[idx][31:16]};
  endfunction

  // Target of a redirect command, kind 4 + PC mux code
  function automatic logic [31:0] redirect_target(input int kind, input logic [31:0] value);
    case (kind)
      4:       return {value[31:2], 2'b00};
      5, 6, 7: return {value[31:1], 1'b0};
      8:       return {value[24:0], 7'b0000000};          // mtvec base
      9:       return {value[29:5], value[4:0], 2'b00};   // mtvec plus irq slot
      default: return 32'h0;
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    n_errors++;
  endtask

  // Returns on the clock edge where ID has taken n entries
  task automatic wait_accepted(input int n);
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
      if (cyc > WAIT_LIMIT) begin
        $display("Timeout: ID never took entry %0d, only %0d seen", n, n_accepted);
        timed_out = 1'b1;
      end
    end while (n_accepted < n && !timed_out);
  endtask

  task automatic apply_cmd(input int kind, input logic [31:0] value);
    case (kind)
      1: id_ready_i = value[0];
      2: halt_if_i  = value[0];
      3: kill_if_i  = value[0];
      default: begin
        pc_mux_i        = pc_mux_e'(3'(kind - 4));
        boot_addr_i     = value;
        jump_target_i   = value;
        branch_target_i = value;
        mepc_i          = value;
        mtvec_addr_i    = (kind == 9) ? value[29:5] : value[24:0];
        irq_id_i        = value[4:0];
        redirect_pc     = redirect_target(kind, value);
        redirect_pend   = 1'b1;
        if (kind == 4) begin
          boot_pc   = redirect_pc;
          boot_pend = 1'b1;
        end
        pc_set_i = 1'b1;
        @(posedge clk);
        #10;
        pc_set_i = 1'b0;  // One cycle strobe
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  always begin
    @(posedge clk);
    #10;
    fetch_valid_i = 1'b0;
    if (mem_busy) begin
      if (mem_lat <= 1) begin
        fetch_valid_i = 1'b1;
        fetch_rdata_i = read_parcels(mem_addr);
        mem_busy      = 1'b0;
      end else begin
        mem_lat--;
      end
    end
    if (rst_n && fetch_req_o) begin
      if (boot_pend) begin
        n_checks++;
        if (fetch_addr_o !== boot_pc) report_mismatch("boot fetch address", fetch_addr_o, boot_pc);
        boot_pend = 1'b0;
      end
      mem_busy = 1'b1;
      mem_addr = fetch_addr_o;
      mem_lat  = 1 + int'($unsigned($random(seed)) % 3);  // 1 to 3 cycles
    end
  end

  //////////////////////////////////////////////////
  // IF/ID checker, mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    int          e;
    logic [31:0] raw_exp;  // Image word at the entry PC
    if (rst_n) begin
      if (csr_mtvec_init_o) n_mtvec_init++;
      // Stalled entry must not move
      if (stall_q) begin
        n_checks++;
        if (!id_valid_o) report_mismatch("valid during stall", 32'(id_valid_o), 32'h1);
        if (id_pc_o !== held_pc) report_mismatch("pc during stall", id_pc_o, held_pc);
        if (id_instr_o !== held_instr) report_mismatch("instr during stall", id_instr_o, held_instr);
      end
      stall_q    = id_valid_o && !id_ready_i;
      held_pc    = id_pc_o;
      held_instr = id_instr_o;
      if (id_valid_o && id_ready_i) begin
        e = EXP_BASE + 3 * n_accepted;
        if (n_accepted < n_exp) begin
          n_checks++;
          raw_exp = read_parcels(tdata[e]);
          if (id_pc_o !== tdata[e]) report_mismatch("id_pc", id_pc_o, tdata[e]);
          if (id_instr_o !== tdata[e+1]) report_mismatch("id_instr", id_instr_o, tdata[e+1]);
          if (id_compressed_o !== tdata[e+2][1])
            report_mismatch("id_compressed", 32'(id_compressed_o), 32'(tdata[e+2][1]));
          if (id_illegal_o !== tdata[e+2][0])
            report_mismatch("id_illegal", 32'(id_illegal_o), 32'(tdata[e+2][0]));
          if (id_raw_half_o !== raw_exp[15:0])
            report_mismatch("raw half", 32'(id_raw_half_o), 32'(raw_exp[15:0]));
        end
        if (redirect_pend) begin
          n_checks++;
          if (id_pc_o !== redirect_pc) report_mismatch("redirect pc", id_pc_o, redirect_pc);
          redirect_pend = 1'b0;
        end
        n_accepted++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    seed     = 32'h44a3;
    rst_n    = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    halt_if_i       = 1'b0;
    kill_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    fetch_valid_i   = 1'b0;
    fetch_rdata_i   = '0;
    // Background words, every one a 32-bit opcode
    for (int i = 0; i < MEM_WORDS; i++) begin
      tdata[i] = {16'hF00D ^ 16'(i), 14'(i), 2'b11};
    end
    $readmemh("tests/if_stage_testdata.txt", tdata);
    n_exp = 0;
    while (tdata[EXP_BASE + 3 * n_exp] !== 32'hFFFFFFFF) n_exp++;

    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;

    // Command player
    for (int c = CMD_BASE; tdata[c+2] != 0 && !timed_out; c += 4) begin
      wait_accepted(int'(tdata[c]));
      if (!timed_out) begin
        repeat (int'(tdata[c+1])) @(posedge clk);
        #10;
        apply_cmd(int'(tdata[c+2]), tdata[c+3]);
      end
    end
    if (!timed_out) wait_accepted(n_exp);

    n_checks++;
    if (n_mtvec_init != 1) begin
      $display("FAILED at %0t: mtvec init pulsed %0d times", $time, n_mtvec_init);
      n_errors++;
    end
    $display("Checks: %0d, errors: %0d, entries: %0d of %0d",
             n_checks, n_errors, n_accepted, n_exp);
    if (n_errors == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: tests/if_stage_testdata.txt
// Memory words at 0x00..0x3F, 32 bits each, little endian halfwords
// Commands at 0x40: entries taken, extra cycles, kind, value (kind 0 ends)
// Kinds: 1 id_ready, 2 halt, 3 kill, 4..9 redirect with PC mux code kind-4
// Expected entries at 0x80: pc, instr, {compressed, illegal}; FFFFFFFF ends
@04
03930085 517D0050 929A8192 00738433
00000001 05138082 05930010 000100A0
00010001
@10
00A00593 00010001
@14
00850001 00010001
@20
00738433
@23
517D517D
@40
00000000 00000000 00000004 00000013
00000003 00000002 00000001 00000000
00000003 00000005 00000001 00000001
00000006 00000001 00000002 00000001
00000006 00000005 00000002 00000000
00000009 00000000 00000001 00000000
00000009 00000006 00000003 00000001
00000009 00000000 00000003 00000000
00000009 00000000 00000001 00000001
0000000B 00000000 00000005 00000041
0000000D 00000000 00000006 00000052
0000000E 00000000 00000007 00000026
0000000F 00000000 00000008 00000001
00000010 00000000 00000009 00000023
00000000 00000000 00000000 00000000
@80
00000010 00108093 00000002
00000012 00500393 00000000
00000016 FFF00113 00000002
00000018 004001B3 00000002
0000001A 006282B3 00000002
0000001C 00738433 00000000
00000020 00000013 00000002
00000022 80820000 00000003
00000024 05138082 00000003
0000002A 00A00593 00000000
0000002E 00000013 00000002
00000040 00A00593 00000000
00000044 00000013 00000002
00000052 00108093 00000002
00000026 00100513 00000000
00000080 00738433 00000000
0000008C FFF00113 00000002
FFFFFFFF

// File: sources.f
logic/if_stage_pkg.sv
logic/pc_select.sv
logic/fetch_unit.sv
logic/rvc_expander.sv
logic/if_id_register.sv
logic/if_stage.sv
tests/tb_if_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the IF stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_if_stage \
  --Mdir obj_dir -o tb_if_stage > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/tb_if_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
